/* Makefile */
# build and run the link kernel testbench with Verilator

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps \
	  --top-module link_kernel_tb -f verilog.f -o link_kernel_sim
	@out=$$(./obj_dir/link_kernel_sim); echo "$$out"; \
	  echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

/* source/link_calib_master.sv */
`timescale 1ns/10ps
`default_nettype none

`include "link_macros.svh"

module link_calib_master
  (input  logic                                       io_master_clk_i
  ,input  logic                                       reset_i
  // last valid word seen by each input lane
  ,input  link_pkg::link_data_t [`LINK_CHANNELS-1:0] snoop_i
  // channel controls
  ,output logic                                       prepare_o
  ,output logic                                       override_o
  // reset line toward the slave
  ,output logic                                       slave_reset_o
  ,output logic                                       calib_done_o
  ,output link_pkg::link_chan_mask_t                  active_o);

  // one counter shared by all phases, sized for the longest
  localparam int cnt_width_lp =
    $clog2(`LINK_WAIT_CYCLES + `LINK_PREPARE_CYCLES + `LINK_TEST_CYCLES);

  link_pkg::calib_state_e    state_r;
  link_pkg::calib_state_e    state_n;
  logic [cnt_width_lp-1:0]   cnt_r;
  logic                      slave_reset_r;
  logic                      done_r;
  link_pkg::link_chan_mask_t active_r;
  link_pkg::link_chan_mask_t match;

  // ----------------------------------------
  // phase sequencing
  // ----------------------------------------

  // wait ends one cycle early because the slave reset
  // line is a registered copy of the prepare state
  always_comb begin
    state_n = state_r;
    case (state_r)
      link_pkg::CALIB_WAIT:
        if (cnt_r == cnt_width_lp'(`LINK_WAIT_CYCLES - 2))
          state_n = link_pkg::CALIB_PREPARE;
      link_pkg::CALIB_PREPARE:
        if (cnt_r == cnt_width_lp'(`LINK_PREPARE_CYCLES - 1))
          state_n = link_pkg::CALIB_TEST;
      link_pkg::CALIB_TEST:
        if (cnt_r == cnt_width_lp'(`LINK_TEST_CYCLES - 1))
          state_n = link_pkg::CALIB_DONE;
      // done holds until the next reset
      default:
        state_n = link_pkg::CALIB_DONE;
    endcase
  end

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      state_r <= link_pkg::CALIB_WAIT;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      // restart count on every phase change, park once done
      if (state_n != state_r)
        cnt_r <= '0;
      else if (state_r != link_pkg::CALIB_DONE)
        cnt_r <= cnt_r + 1'b1;
    end
  end

  // channels get reset and credits reloaded during prepare
  assign prepare_o  = (state_r == link_pkg::CALIB_PREPARE);
  // output lanes drive the pattern during test
  assign override_o = (state_r == link_pkg::CALIB_TEST);

  // ----------------------------------------
  // slave reset and lane activation
  // ----------------------------------------

  // lane passes if it snooped the pattern and is selected
  always_comb begin
    for (int i = 0; i < `LINK_CHANNELS; i++) begin
      match[i] = (snoop_i[i] == `LINK_CALIB_PATTERN);
    end
  end

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i) begin
      slave_reset_r <= 1'b0;
      done_r        <= 1'b0;
      active_r      <= '0;
    end else begin
      slave_reset_r <= prepare_o;
      // first done cycle latches the result, so done and mask rise together
      if ((state_r == link_pkg::CALIB_DONE) && !done_r) begin
        done_r   <= 1'b1;
        active_r <= match & `LINK_CHANNEL_SELECT;
      end
    end
  end

  assign slave_reset_o = slave_reset_r;
  assign calib_done_o  = done_r;
  assign active_o      = active_r;

endmodule

`default_nettype wire

/* source/link_channel_in.sv */
`timescale 1ns/10ps
`default_nettype none

`include "link_macros.svh"

module link_channel_in
  (input  logic                 io_master_clk_i
  ,input  logic                 reset_i
  // fifo stays cleared until calibration finishes
  ,input  logic                 calib_done_i
  // incoming line
  ,input  link_pkg::link_word_t tline_i
  // core receive side, valid/yumi
  ,output link_pkg::link_word_t core_out_o
  ,input  logic                 core_yumi_i
  // one cycle strobe back to the sender
  ,output logic                 token_o
  // last valid line word, for calibration
  ,output link_pkg::link_data_t snoop_o);

  localparam int depth_lp = 1 << `LINK_LG_FIFO_DEPTH;

  link_pkg::link_data_t           mem_r [depth_lp];
  // extra msb tells full from empty
  logic [`LINK_LG_FIFO_DEPTH:0]   wr_ptr_r;
  logic [`LINK_LG_FIFO_DEPTH:0]   rd_ptr_r;
  logic                           fifo_reset;
  logic                           enq;
  logic                           deq;
  logic                           empty;
  logic [`LINK_LG_DECIMATION-1:0] dec_r;
  logic                           token_r;
  link_pkg::link_data_t           snoop_r;

  // ----------------------------------------
  // input fifo
  // ----------------------------------------

  assign fifo_reset = reset_i | ~calib_done_i;

  // sender credits keep the fifo from ever overflowing
  assign enq   = tline_i.valid & ~fifo_reset;
  assign empty = (wr_ptr_r == rd_ptr_r);
  assign deq   = core_yumi_i & ~empty;

  // storage, written at the edge the word arrives
  always_ff @(posedge io_master_clk_i) begin
    if (enq)
      mem_r[wr_ptr_r[`LINK_LG_FIFO_DEPTH-1:0]] <= tline_i.data;
  end

  always_ff @(posedge io_master_clk_i) begin
    if (fifo_reset) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (enq)
        wr_ptr_r <= wr_ptr_r + 1'b1;
      if (deq)
        rd_ptr_r <= rd_ptr_r + 1'b1;
    end
  end

  // head word, valid whenever something is queued
  assign core_out_o = '{valid: ~empty, data: mem_r[rd_ptr_r[`LINK_LG_FIFO_DEPTH-1:0]]};

  // ----------------------------------------
  // token return
  // ----------------------------------------

  // count dequeues, strobe once per full decimation batch
  always_ff @(posedge io_master_clk_i) begin
    if (fifo_reset) begin
      dec_r   <= '0;
      token_r <= 1'b0;
    end else begin
      token_r <= deq & (dec_r == '1);
      if (deq)
        dec_r <= dec_r + 1'b1;
    end
  end

  assign token_o = token_r;

  // snoop runs even while the fifo is held, that is when
  // the calibration pattern shows up
  always_ff @(posedge io_master_clk_i) begin
    if (reset_i)
      snoop_r <= '0;
    else if (tline_i.valid)
      snoop_r <= tline_i.data;
  end

  assign snoop_o = snoop_r;

endmodule

`default_nettype wire

/* source/link_channel_out.sv */
`timescale 1ns/10ps
`default_nettype none

`include "link_macros.svh"

module link_channel_out
  (input  logic                 io_master_clk_i
  ,input  logic                 reset_i
  // from calibration master
  ,input  logic                 prepare_i
  ,input  logic                 override_i
  ,input  logic                 active_i
  // core send side, valid/ready
  ,input  link_pkg::link_word_t core_in_i
  ,output logic                 core_ready_o
  // one cycle strobe per returned token
  ,input  logic                 token_i
  // outgoing line
  ,output link_pkg::link_word_t tline_o);

  link_pkg::link_credit_t credits_r;
  link_pkg::link_credit_t token_credits;
  logic                   accept;
  link_pkg::link_word_t   line_n;
  logic                   line_valid_r;
  link_pkg::link_data_t   line_data_r;

  // ----------------------------------------
  // credit flow control
  // ----------------------------------------

  // no sending until calibration marks the lane active
  assign core_ready_o = active_i & (credits_r != '0);
  assign accept       = core_in_i.valid & core_ready_o;

  // each token stands for a decimated batch of freed slots
  assign token_credits = token_i ?
    link_pkg::link_credit_t'(1 << `LINK_LG_DECIMATION) : '0;

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i)
      credits_r <= '0;
    // start with one credit per remote fifo slot
    else if (prepare_i)
      credits_r <= link_pkg::link_credit_t'(1 << `LINK_LG_FIFO_DEPTH);
    // spend and refill may land in the same cycle
    else
      credits_r <= credits_r - link_pkg::link_credit_t'(accept) + token_credits;
  end

  // ----------------------------------------
  // line driver
  // ----------------------------------------

  // calibration pattern wins over core traffic
  always_comb begin
    if (override_i)
      line_n = '{valid: 1'b1, data: `LINK_CALIB_PATTERN};
    else if (accept)
      line_n = core_in_i;
    else
      line_n = '{valid: 1'b0, data: line_data_r};
  end

  always_ff @(posedge io_master_clk_i) begin
    if (reset_i)
      line_valid_r <= 1'b0;
    else
      line_valid_r <= line_n.valid;
  end

  // data only moves with a valid word, line stays quiet otherwise
  always_ff @(posedge io_master_clk_i) begin
    if (line_n.valid)
      line_data_r <= line_n.data;
  end

  assign tline_o = '{valid: line_valid_r, data: line_data_r};

endmodule

`default_nettype wire

/* source/link_kernel.sv */
`timescale 1ns/10ps
`default_nettype none

`include "link_macros.svh"

module link_kernel
  (input  logic                                       io_master_clk_i
  ,input  logic                                       reset_i
  // core send
  ,input  link_pkg::link_word_t [`LINK_CHANNELS-1:0] core_in_i
  ,output link_pkg::link_chan_mask_t                  core_ready_o
  // core receive
  ,output link_pkg::link_word_t [`LINK_CHANNELS-1:0] core_out_o
  ,input  link_pkg::link_chan_mask_t                  core_yumi_i
  // line side
  ,output link_pkg::link_word_t [`LINK_CHANNELS-1:0] tline_o
  ,input  link_pkg::link_word_t [`LINK_CHANNELS-1:0] tline_i
  // token strobes, out for received words, in for sent ones
  ,output link_pkg::link_chan_mask_t                  token_o
  ,input  link_pkg::link_chan_mask_t                  token_i
  // calibration status
  ,output logic                                       slave_reset_o
  ,output logic                                       calib_done_o
  ,output link_pkg::link_chan_mask_t                  active_channels_o);

  logic                                       prepare;
  logic                                       override;
  link_pkg::link_data_t [`LINK_CHANNELS-1:0] snoop;

  // ----------------------------------------
  // calibration master
  // ----------------------------------------

  link_calib_master calib
    (.io_master_clk_i(io_master_clk_i)
    ,.reset_i        (reset_i)
    ,.snoop_i        (snoop)
    ,.prepare_o      (prepare)
    ,.override_o     (override)
    ,.slave_reset_o  (slave_reset_o)
    ,.calib_done_o   (calib_done_o)
    ,.active_o       (active_channels_o));

  // ----------------------------------------
  // per lane output and input sides
  // ----------------------------------------

  for (genvar i = 0; i < `LINK_CHANNELS; i++) begin : ch

    // sends core words, spends credits, refilled by tokens
    link_channel_out sso
      (.io_master_clk_i(io_master_clk_i)
      ,.reset_i        (reset_i)
      ,.prepare_i      (prepare)
      ,.override_i     (override)
      ,.active_i       (active_channels_o[i])
      ,.core_in_i      (core_in_i[i])
      ,.core_ready_o   (core_ready_o[i])
      ,.token_i        (token_i[i])
      ,.tline_o        (tline_o[i]));

    // queues line words, returns tokens, snoops for calibration
    link_channel_in ssi
      (.io_master_clk_i(io_master_clk_i)
      ,.reset_i        (reset_i)
      ,.calib_done_i   (calib_done_o)
      ,.tline_i        (tline_i[i])
      ,.core_out_o     (core_out_o[i])
      ,.core_yumi_i    (core_yumi_i[i])
      ,.token_o        (token_o[i])
      ,.snoop_o        (snoop[i]));

  end

endmodule

`default_nettype wire

/* source/link_macros.svh */
`ifndef LINK_MACROS_SVH
`define LINK_MACROS_SVH

// ----------------------------------------
// link geometry
// ----------------------------------------

// number of lanes on the link
`define LINK_CHANNELS 2
// data bits carried per line word
`define LINK_WIDTH 8
// log2 of input fifo depth, also the starting credit count
`define LINK_LG_FIFO_DEPTH 3
// log2 of words consumed per returned token
`define LINK_LG_DECIMATION 1

// ----------------------------------------
// calibration sequence
// ----------------------------------------

// idle cycles after reset before the slave gets reset
`define LINK_WAIT_CYCLES 16
// cycles the slave reset line is held high
`define LINK_PREPARE_CYCLES 12
// cycles the test pattern is driven on every lane
`define LINK_TEST_CYCLES 8
// word the input side must snoop for a lane to pass
`define LINK_CALIB_PATTERN 8'hA5
// lanes allowed to go active after calibration
`define LINK_CHANNEL_SELECT 2'b11

`endif

/* source/link_pkg.sv */
`default_nettype none

`include "link_macros.svh"

package link_pkg;

  // one data word on a lane
  typedef logic [`LINK_WIDTH-1:0] link_data_t;

  // word as it travels on line and core ports
  // valid sits in the msb, data below it
  typedef struct packed {
    logic       valid;
    link_data_t data;
  } link_word_t;

  // credit count, one extra bit so a full fifo worth fits
  typedef logic [`LINK_LG_FIFO_DEPTH:0] link_credit_t;

  // one bit per lane
  typedef logic [`LINK_CHANNELS-1:0] link_chan_mask_t;

  // calibration master sequence
  typedef enum logic [1:0] {
    CALIB_WAIT,
    CALIB_PREPARE,
    CALIB_TEST,
    CALIB_DONE
  } calib_state_e;

endpackage

`default_nettype wire

/* verification/link_kernel_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "link_macros.svh"

module link_kernel_assertions
  (input logic                      io_master_clk_i
  ,input logic                      reset_i
  ,input link_pkg::link_chan_mask_t ready_i
  ,input link_pkg::link_chan_mask_t token_i
  ,input logic                      slave_reset_i
  ,input logic                      calib_done_i);

  // no lane takes core words before calibration is over
  ready_needs_done: assert property (@(posedge io_master_clk_i) disable iff (reset_i)
    (ready_i != '0) |-> calib_done_i)
    else $error("core_ready_o high before calib_done_o");

  // decimation keeps token strobes apart
  for (genvar i = 0; i < `LINK_CHANNELS; i++) begin : lane
    token_spacing: assert property (@(posedge io_master_clk_i) disable iff (reset_i)
      token_i[i] |=> !token_i[i])
      else $error("token_o pulsed in consecutive cycles on lane %0d", i);
  end

  // slave held in reset only while calibration runs
  reset_excludes_done: assert property (@(posedge io_master_clk_i) disable iff (reset_i)
    !(slave_reset_i && calib_done_i))
    else $error("slave_reset_o high together with calib_done_o");

endmodule

bind link_kernel link_kernel_assertions checks
  (.io_master_clk_i(io_master_clk_i)
  ,.reset_i        (reset_i)
  ,.ready_i        (core_ready_o)
  ,.token_i        (token_o)
  ,.slave_reset_i  (slave_reset_o)
  ,.calib_done_i   (calib_done_o));

`default_nettype wire

/* verification/link_kernel_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "link_macros.svh"

module link_kernel_tb;

  localparam int fifo_words_lp = 1 << `LINK_LG_FIFO_DEPTH;
  localparam int batch_lp      = 1 << `LINK_LG_DECIMATION;
  localparam int timeout_lp    = 200;

  logic                                       clk;
  logic                                       reset;
  // flips lane 1 data on the way back
  logic                                       fault;
  link_pkg::link_word_t [`LINK_CHANNELS-1:0] core_in;
  link_pkg::link_word_t [`LINK_CHANNELS-1:0] core_out;
  link_pkg::link_word_t [`LINK_CHANNELS-1:0] line_out;
  link_pkg::link_word_t [`LINK_CHANNELS-1:0] line_back;
  link_pkg::link_chan_mask_t                  core_ready;
  link_pkg::link_chan_mask_t                  core_yumi;
  link_pkg::link_chan_mask_t                  token_out;
  link_pkg::link_chan_mask_t                  active;
  logic                                       slave_reset;
  logic                                       calib_done;
  logic [7:0]                                 lfsr;
  // token pulses seen per lane
  int                                         tokens [`LINK_CHANNELS];

  // tokens loop straight back into the sender
  link_kernel DUT
    (.io_master_clk_i  (clk)
    ,.reset_i          (reset)
    ,.core_in_i        (core_in)
    ,.core_ready_o     (core_ready)
    ,.core_out_o       (core_out)
    ,.core_yumi_i      (core_yumi)
    ,.tline_o          (line_out)
    ,.tline_i          (line_back)
    ,.token_o          (token_out)
    ,.token_i          (token_out)
    ,.slave_reset_o    (slave_reset)
    ,.calib_done_o     (calib_done)
    ,.active_channels_o(active));

  always #4 clk = ~clk;

  // external line loopback
  always_comb begin
    line_back = line_out;
    if (fault)
      line_back[1].data = ~line_out[1].data;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // galois lfsr, x^8+x^6+x^5+x^4+1
  function automatic logic [7:0] step_lfsr(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  // one lfsr step per data bit taken
  function automatic link_pkg::link_data_t next_data();
    link_pkg::link_data_t d;
    d = '0;
    for (int b = 0; b < `LINK_WIDTH; b++) begin
      d    = {d[`LINK_WIDTH-2:0], lfsr[0]};
      lfsr = step_lfsr(lfsr);
    end
    return d;
  endfunction

  task automatic abort(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
    if (actual !== expected)
      abort($sformatf("FAIL %0t: %s, got %0h, expected %0h", $time, what, actual, expected));
  endtask

  // step to 1 ns past the next rising edge, where inputs change and outputs are stable
  task automatic next_cycle();
    @(posedge clk);
    #1;
    for (int i = 0; i < `LINK_CHANNELS; i++)
      if (token_out[i])
        tokens[i]++;
  endtask

  task automatic apply_reset();
    reset     = 1'b1;
    core_in   = '0;
    core_yumi = '0;
    repeat (8) next_cycle();
    reset = 1'b0;
    compare(32'(calib_done), 0, "calib_done_o after reset");
    compare(32'(core_ready), 0, "core_ready_o after reset");
    compare(32'(slave_reset), 0, "slave_reset_o after reset");
    compare(32'(active), 0, "active_channels_o after reset");
    compare(32'(token_out), 0, "token_o after reset");
    for (int i = 0; i < `LINK_CHANNELS; i++)
      compare(32'(line_out[i].valid), 0, "tline_o valid after reset");
  endtask

  task automatic wait_calib_done();
    int n;
    n = 0;
    while (!calib_done) begin
      next_cycle();
      n++;
      if (n > timeout_lp)
        abort("timed out waiting for calib_done_o");
    end
  endtask

  // send count random words on the lanes in mask with yumi high, check order
  // lanes left out of the mask must keep core_ready_o low
  task automatic stream_words(input int count, input link_pkg::link_chan_mask_t lanes);
    link_pkg::link_data_t words [`LINK_CHANNELS][32];
    int                   sent [`LINK_CHANNELS];
    int                   got [`LINK_CHANNELS];
    int                   n;
    logic                 busy;
    for (int i = 0; i < `LINK_CHANNELS; i++) begin
      sent[i] = 0;
      got[i]  = 0;
      for (int k = 0; k < count; k++)
        words[i][k] = next_data();
    end
    core_yumi = lanes;
    n         = 0;
    busy      = 1'b1;
    while (busy) begin
      busy = 1'b0;
      for (int i = 0; i < `LINK_CHANNELS; i++) begin
        if (lanes[i]) begin
          // head word leaves at the next edge since yumi is high
          if (core_out[i].valid) begin
            if (got[i] >= count)
              abort("core_out_o delivered more words than were sent");
            compare(32'(core_out[i].data), 32'(words[i][got[i]]), "core_out_o data order");
            got[i]++;
          end
          core_in[i] = '0;
          if (sent[i] < count) begin
            core_in[i] = '{valid: 1'b1, data: words[i][sent[i]]};
            if (core_ready[i])
              sent[i]++;
          end
          if (got[i] < count)
            busy = 1'b1;
        end else begin
          compare(32'(core_ready[i]), 0, "core_ready_o on a shut lane");
        end
      end
      // one more edge so the last word is dequeued
      next_cycle();
      n++;
      if (n > timeout_lp)
        abort("timed out streaming words through the link");
    end
    core_in   = '0;
    core_yumi = '0;
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------

  task automatic calibration_sequence();
    int n;
    n = 0;
    while (!slave_reset) begin
      next_cycle();
      n++;
      if (n > timeout_lp)
        abort("slave_reset_o never rose");
    end
    compare(n, `LINK_WAIT_CYCLES, "cycles from reset to slave_reset_o");
    n = 0;
    while (slave_reset) begin
      next_cycle();
      n++;
      if (n > timeout_lp)
        abort("slave_reset_o never fell");
    end
    compare(n, `LINK_PREPARE_CYCLES, "cycles slave_reset_o stays high");
    // test phase, pattern on every lane
    for (int c = 0; c < `LINK_TEST_CYCLES; c++) begin
      for (int i = 0; i < `LINK_CHANNELS; i++)
        compare(32'(line_out[i]), 32'({1'b1, `LINK_CALIB_PATTERN}), "tline_o pattern");
      compare(32'(calib_done), 0, "calib_done_o during test");
      next_cycle();
    end
    compare(32'(calib_done), 1, "calib_done_o after test");
    compare(32'(active), 32'(`LINK_CHANNEL_SELECT), "active_channels_o");
  endtask

  task automatic ordered_transfer();
    stream_words(20, '1);
  endtask

  task automatic back_pressure(input int lane);
    link_pkg::link_data_t words [fifo_words_lp];
    int                   accepted;
    int                   got;
    int                   n;
    accepted  = 0;
    core_yumi = '0;
    // let returning tokens settle
    repeat (2) next_cycle();
    while (core_ready[lane]) begin
      if (accepted == fifo_words_lp)
        abort("lane accepted more words than its credits allow");
      words[accepted] = next_data();
      core_in[lane]   = '{valid: 1'b1, data: words[accepted]};
      accepted++;
      next_cycle();
    end
    core_in[lane] = '0;
    compare(accepted, fifo_words_lp, "words accepted before core_ready_o fell");
    repeat (4) begin
      next_cycle();
      compare(32'(core_ready[lane]), 0, "core_ready_o with a full fifo");
    end
    // release yumi and drain
    core_yumi[lane] = 1'b1;
    got = 0;
    n   = 0;
    while (got < accepted) begin
      if (core_out[lane].valid) begin
        compare(32'(core_out[lane].data), 32'(words[got]), "drained word order");
        got++;
      end
      next_cycle();
      n++;
      if (n > timeout_lp)
        abort("timed out draining the input fifo");
    end
    core_yumi[lane] = 1'b0;
    n = 0;
    while (!core_ready[lane]) begin
      next_cycle();
      n++;
      if (n > timeout_lp)
        abort("core_ready_o did not return after draining");
    end
  endtask

  task automatic token_decimation();
    // strobes from the last drain are still on their way
    repeat (2) next_cycle();
    for (int i = 0; i < `LINK_CHANNELS; i++)
      tokens[i] = 0;
    stream_words(16, '1);
    // final strobe comes the cycle after the last dequeue
    repeat (2) next_cycle();
    for (int i = 0; i < `LINK_CHANNELS; i++)
      compare(tokens[i], 16 / batch_lp, "token_o pulses over 16 dequeues");
  endtask

  task automatic failed_lane();
    fault = 1'b1;
    apply_reset();
    wait_calib_done();
    compare(32'(active), 32'(1), "active_channels_o with lane 1 broken");
    // lane 0 still moves data, lane 1 stays shut
    stream_words(20, link_pkg::link_chan_mask_t'(1));
    fault = 1'b0;
  endtask

  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    fault     = 1'b0;
    core_in   = '0;
    core_yumi = '0;
    lfsr      = 8'd54;
    apply_reset();
    calibration_sequence();
    ordered_transfer();
    back_pressure(0);
    back_pressure(1);
    token_decimation();
    failed_lane();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+source
source/link_pkg.sv
source/link_calib_master.sv
source/link_channel_out.sv
source/link_channel_in.sv
source/link_kernel.sv
verification/link_kernel_assertions.sv
verification/link_kernel_tb.sv
